/* filelist.f */
rtl/zport_pkg.sv
rtl/zcfg_pkg.sv
rtl/bus_strobe.sv
rtl/port_decode.sv
rtl/config_regs.sv
rtl/ulaplus_ctrl.sv
rtl/read_mux.sv
rtl/zports_top.sv
bench/tb_clock.sv
bench/zports_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, fail on the fail message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module zports_tb -Mdir obj_dir -o zports_sim -f filelist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/zports_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
if grep -q '\*\* FAIL \*\*' sim.log; then
	exit 1
fi
exit 0

/* bench/zports_tb.sv */
/*
 Testbench of the port block: random z80 i/o cycles against a model
 of the port map and registers, pulse counters and a watchdog.
*/
`timescale 1ns/1ps
`default_nettype none

module zports_tb;
	import zport_pkg::*;
	import zcfg_pkg::*;

	localparam int n_fe = 16; // loop lengths of the tests
	localparam int n_pg = 40;
	localparam int n_rd = 24;
	localparam int n_up = 4;
	localparam int n_brk = 6;
	localparam int cycle_clks = 22; // one bus cycle plus slack
	localparam int n_cycles = n_fe + n_pg + n_rd + 6 * n_up + 5 * n_brk + 20;
	localparam int watchdog_ns = n_cycles * cycle_clks * 4 + 500;

	logic fclk, zpos, rst_n, dos, iorq_n, rd_n, wr_n, tape_read;
	addr_t a;
	data_t din, mus_in, dout, p7ffd, peff7, up_paldata;
	logic [4:0] keys_in, kj_in;
	logic dataout, porthit, pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic romrw_en, font_wr_en, set_nmi, brk_ena, clr_nmi, beeper_wr, up_ena, up_palwr;
	border_t border;
	page_t pent1m_page, up_paladdr;
	addr_t brk_addr;

	// reference model state
	border_t m_border;
	data_t m_p7ffd, m_peff7, m_up_last;
	logic [4:0] m_bf;
	addr_t m_brk;
	logic m_up_pal, m_up_ena;
	page_t m_up_addr;

	logic [31:0] lfsr = 32'hc695;
	int n_beep = 0; // strobe pulse counters
	int n_clr = 0;
	int n_pal = 0;
	data_t pal_seen;
	page_t pal_addr_seen;

	tb_clock u_clk (.fclk, .zpos);

	zports_top u_dut (.*);

	always @(posedge fclk)
	begin
		if (beeper_wr)
			n_beep <= n_beep + 1;
		if (clr_nmi)
			n_clr <= n_clr + 1;
		if (up_palwr)
		begin
			n_pal         <= n_pal + 1;
			pal_seen      <= up_paldata; // din still held here
			pal_addr_seen <= up_paladdr;
		end
	end

	////////////////////
	// helpers

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]}; // one step per bit
		end
		return r;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s got %h expected %h", what, got, exp);
			$display("** FAIL **");
			$fatal(1, "first mismatch, run stopped");
		end
	endtask

	function automatic logic exp_hit(input addr_t ad);
		loa_t l;
		logic sh;
		l = ad[7:0];
		sh = dos | m_bf[bf_shadow];
		return (l inside {port_fe, port_f6, port_fd, port_kmouse, port_zxevbf,
			port_zxevbe, port_zxevbrk, port_ulaplus}) ||
			((l == port_kjoy || l == port_f7) && !sh); // hidden in shadow
	endfunction

	function automatic data_t exp_read(input addr_t ad);
		logic sh;
		sh = dos | m_bf[bf_shadow];
		case (ad[7:0])
			port_fe, port_f6: return {1'b1, tape_read, 1'b0, keys_in};
			port_kjoy:        return sh ? 8'hFF : {3'b000, kj_in};
			port_kmouse:      return mus_in;
			port_zxevbf:      return {3'b000, m_bf[4:1], sh};
			port_ulaplus:     return m_up_last;
			port_zxevbe:
				case (ad[12:8])
					be_p7ffd:  return m_p7ffd;
					be_peff7:  return m_peff7;
					be_border: return {4'hF, m_border};
					be_brk_lo: return m_brk[7:0];
					be_brk_hi: return m_brk[15:8];
					default:   return 8'hFF;
				endcase
			default:          return 8'hFF;
		endcase
	endfunction

	// register rules of the port map
	task automatic model_write(input addr_t ad, input data_t d);
		loa_t l;
		l = ad[7:0];
		if (l == port_fe || l == port_f6)
			m_border = {~ad[3], d[2:0]};
		if (l == port_fd && !ad[15] && !(m_p7ffd[p7ffd_lock] && m_peff7[eff7_block1m]))
			m_p7ffd = d;
		if (l == port_f7 && ad[8] && !ad[12] && !(dos || m_bf[bf_shadow]))
			m_peff7 = d;
		if (l == port_zxevbf)
			m_bf = d[4:0];
		if (l == port_zxevbrk && ad[8])
			m_brk[15:8] = d;
		else if (l == port_zxevbrk)
			m_brk[7:0] = d;
		if (l == port_ulaplus && !ad[14] && d[7:6] == 2'b01)
			m_up_pal = 1'b1;
		else if (l == port_ulaplus && !ad[14] && d[7:6] == 2'b00)
		begin
			m_up_pal  = 1'b0;
			m_up_addr = d[5:0];
		end
		else if (l == port_ulaplus && ad[14])
		begin
			m_up_last = d;
			if (!m_up_pal)
				m_up_ena = d[0];
		end
	endtask

	task automatic check_regs;
		data_t e7;
		data_t ee;
		e7 = m_p7ffd;
		ee = m_peff7;
		if (m_peff7[eff7_block1m])
		begin
			e7[7:5] = 3'b000; // 128k view
			ee = ee & ~8'b0100_1110;
		end
		check("p7ffd", 32'(p7ffd), 32'(e7));
		check("peff7", 32'(peff7), 32'(ee));
		check("pent1m_page", 32'(pent1m_page), 32'({m_p7ffd[7:5], m_p7ffd[2:0]}));
		check("pent1m_rom", 32'(pent1m_rom), 32'(m_p7ffd[4]));
		check("pent1m_1m_on", 32'(pent1m_1m_on), 32'(!m_peff7[eff7_block1m]));
		check("pent1m_ram0_0", 32'(pent1m_ram0_0), 32'(m_peff7[eff7_ram0]));
		check("border", 32'(border), 32'(m_border));
		check("romrw_en", 32'(romrw_en), 32'(m_bf[bf_romrw]));
		check("font_wr_en", 32'(font_wr_en), 32'(m_bf[bf_fntw]));
		check("set_nmi", 32'(set_nmi), 32'(m_bf[bf_nmi]));
		check("brk_ena", 32'(brk_ena), 32'(m_bf[bf_brk]));
		check("up_ena", 32'(up_ena), 32'(m_up_ena));
	endtask

	// one z80 i/o cycle: 3 zpos periods active, 2 idle
	task automatic bus_cycle(input logic wr, input addr_t ad, input data_t d);
		int beep0, clr0, pal0;
		logic exp_pal;
		data_t got_dout;
		logic got_hit, got_oe;
		beep0 = n_beep;
		clr0 = n_clr;
		pal0 = n_pal;
		exp_pal = wr && ad[7:0] == port_ulaplus && ad[14] && m_up_pal;
		@(posedge fclk);
		a      <= ad;
		din    <= d;
		iorq_n <= 1'b0;
		wr_n   <= !wr;
		rd_n   <= wr;
		repeat (6) @(posedge fclk);
		@(negedge fclk); // mid cycle, inputs settled
		got_dout = dout;
		got_hit  = porthit;
		got_oe   = dataout;
		repeat (6) @(posedge fclk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		repeat (8) @(posedge fclk);
		@(negedge fclk);
		check("beeper_wr pulses", n_beep - beep0, 32'(wr && ad[7:0] == port_fe));
		check("clr_nmi pulses", n_clr - clr0, 32'(wr && ad[7:0] == port_zxevbe));
		check("up_palwr pulses", n_pal - pal0, 32'(exp_pal));
		if (exp_pal)
		begin
			check("up_paldata", 32'(pal_seen), 32'({d[4:2], d[7:5], d[1:0]}));
			check("up_paladdr", 32'(pal_addr_seen), 32'(m_up_addr));
		end
		if (wr)
		begin
			model_write(ad, d);
			check_regs();
		end
		else
		begin
			check("dout", 32'(got_dout), 32'(exp_read(ad)));
			check("porthit", 32'(got_hit), 32'(exp_hit(ad)));
			check("dataout", 32'(got_oe), 32'(exp_hit(ad)));
		end
		check("dataout idle", 32'(dataout), 32'h0);
	endtask

	initial
	begin
		#(watchdog_ns);
		$display("watchdog expired before the test sequence finished");
		$display("** FAIL **");
		$fatal(1, "timeout");
	end

	////////////////////
	// test sequence

	initial
	begin
		addr_t ad;
		data_t d;
		page_t pa;
		logic [1:0] sel;
		rst_n <= 1'b0;
		dos <= 1'b0;
		a <= '0;
		din <= '0;
		iorq_n <= 1'b1;
		rd_n <= 1'b1;
		wr_n <= 1'b1;
		keys_in <= '0;
		kj_in <= '0;
		mus_in <= '0;
		tape_read <= 1'b0;
		m_p7ffd = '0;
		m_peff7 = '0;
		m_bf = '0;
		m_up_pal = 1'b0;
		m_up_ena = 1'b0;
		repeat (4) @(posedge fclk);
		rst_n <= 1'b1;
		@(negedge fclk);
		check("p7ffd after reset", 32'(p7ffd), 32'h0);
		check("peff7 after reset", 32'(peff7), 32'h0);
		check("config after reset", 32'({romrw_en, set_nmi, brk_ena, up_ena}), 32'h0);

		// border and beeper
		for (int i = 0; i < n_fe; i++)
		begin
			ad = {8'(rand_bits(8)), (rand_bits(1) != 0) ? port_fe : port_f6};
			d = 8'(rand_bits(8));
			bus_cycle(1'b1, ad, d);
		end
		bus_cycle(1'b0, {3'b000, be_border, port_zxevbe}, 8'h00);

		// paging ports, random then lock and mask
		for (int i = 0; i < n_pg; i++)
		begin
			ad = {8'(rand_bits(8)), (rand_bits(1) != 0) ? port_fd : port_f7};
			d = 8'(rand_bits(8));
			bus_cycle(1'b1, ad, d);
		end
		bus_cycle(1'b1, 16'hEFF7, 8'h04); // block1m on
		bus_cycle(1'b1, 16'h7FFD, 8'h35); // lock bit
		bus_cycle(1'b1, 16'h7FFD, 8'h02); // frozen
		bus_cycle(1'b1, 16'hEFF7, 8'h00);
		bus_cycle(1'b1, 16'h7FFD, 8'hE2);
		bus_cycle(1'b1, 16'hEFF7, 8'h4E); // masked view
		bus_cycle(1'b0, {3'b000, be_p7ffd, port_zxevbe}, 8'h00);
		bus_cycle(1'b0, {3'b000, be_peff7, port_zxevbe}, 8'h00);

		// BF config, then shadow from BF and from dos
		bus_cycle(1'b1, 16'h00BF, {3'b000, 4'(rand_bits(4)), 1'b0});
		bus_cycle(1'b0, 16'h00BF, 8'h00);
		bus_cycle(1'b1, 16'h00BF, 8'h01);
		bus_cycle(1'b1, 16'hEFF7, 8'(rand_bits(8))); // ignored
		bus_cycle(1'b0, 16'h001F, 8'h00);
		bus_cycle(1'b1, 16'h00BF, 8'h00);
		@(posedge fclk);
		dos <= 1'b1;
		bus_cycle(1'b1, 16'hEFF7, 8'(rand_bits(8)));
		bus_cycle(1'b0, 16'h001F, 8'h00);
		bus_cycle(1'b0, 16'h00BF, 8'h00);
		@(posedge fclk);
		dos <= 1'b0;

		// input reads
		for (int i = 0; i < n_rd; i++)
		begin
			@(posedge fclk);
			keys_in <= 5'(rand_bits(5));
			kj_in <= 5'(rand_bits(5));
			mus_in <= 8'(rand_bits(8));
			tape_read <= 1'(rand_bits(1));
			sel = 2'(rand_bits(2));
			case (sel)
				2'd0:    ad = {8'(rand_bits(8)), port_fe};
				2'd1:    ad = {8'(rand_bits(8)), port_kjoy};
				2'd2:    ad = {8'(rand_bits(8)), port_kmouse};
				default: ad = {8'(rand_bits(8)), 4'(rand_bits(4)), 4'h0}; // no port ends in 0
			endcase
			bus_cycle(1'b0, ad, 8'h00);
		end

		// ulaplus palette and mode
		for (int i = 0; i < n_up; i++)
		begin
			pa = 6'(rand_bits(6));
			bus_cycle(1'b1, 16'hBF3B, {2'b00, pa});
			bus_cycle(1'b1, 16'hBF3B, {2'b01, 6'(rand_bits(6))});
			bus_cycle(1'b1, 16'hFF3B, 8'(rand_bits(8)));
			bus_cycle(1'b1, 16'hBF3B, 8'h00);
			d = 8'(rand_bits(8));
			if (i == 0)
				d[0] = 1'b1; // enable at least once
			bus_cycle(1'b1, 16'hFF3B, d);
			bus_cycle(1'b0, 16'hFF3B, 8'h00);
		end

		// breakpoint halves, nmi clear
		for (int i = 0; i < n_brk; i++)
		begin
			ad = {7'(rand_bits(7)), 1'b0, port_zxevbrk};
			bus_cycle(1'b1, ad, 8'(rand_bits(8)));
			ad = {7'(rand_bits(7)), 1'b1, port_zxevbrk};
			bus_cycle(1'b1, ad, 8'(rand_bits(8)));
			check("brk_addr", 32'(brk_addr), 32'(m_brk));
			bus_cycle(1'b0, {3'b000, be_brk_lo, port_zxevbe}, 8'h00);
			bus_cycle(1'b0, {3'b000, be_brk_hi, port_zxevbe}, 8'h00);
		end
		bus_cycle(1'b1, {8'(rand_bits(8)), port_zxevbe}, 8'(rand_bits(8)));

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
/*
 Testbench clock source: fclk with a 4 ns period and the zpos
 enable, high on every fourth fclk cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic fclk,
	output logic zpos
);

	logic       clk_r = 1'b0;
	logic [1:0] phase = 2'd0; // position inside the z80 clock

	always #2 clk_r = ~clk_r;

	always @(posedge clk_r)
		phase <= phase + 2'd1;

	assign fclk = clk_r;
	assign zpos = (phase == 2'd3);

endmodule

`default_nettype wire

/* rtl/zports_top.sv */
/*
 Z80 i/o port block top: bus strobes, port decode, config registers,
 ULAplus control and the read multiplexer.
*/
`timescale 1ns/1ps
`default_nettype none

module zports_top (
	input  wire logic              fclk,
	input  wire logic              rst_n,
	input  wire logic              zpos,
	input  wire logic              dos,
	input  wire zport_pkg::addr_t  a,
	input  wire zport_pkg::data_t  din,
	input  wire logic              iorq_n,
	input  wire logic              rd_n,
	input  wire logic              wr_n,
	input  wire logic [4:0]        keys_in,
	input  wire logic [4:0]        kj_in,
	input  wire zport_pkg::data_t  mus_in,
	input  wire logic              tape_read,
	output zport_pkg::data_t       dout,
	output logic                   dataout,
	output logic                   porthit,
	output zcfg_pkg::border_t      border,
	output zport_pkg::data_t       p7ffd,
	output zport_pkg::data_t       peff7,
	output zcfg_pkg::page_t        pent1m_page,
	output logic                   pent1m_rom,
	output logic                   pent1m_1m_on,
	output logic                   pent1m_ram0_0,
	output logic                   romrw_en,
	output logic                   font_wr_en,
	output logic                   set_nmi,
	output logic                   brk_ena,
	output zport_pkg::addr_t       brk_addr,
	output logic                   clr_nmi,
	output logic                   beeper_wr,
	output logic                   up_ena,
	output zcfg_pkg::page_t        up_paladdr,
	output zport_pkg::data_t       up_paldata,
	output logic                   up_palwr
);
	import zport_pkg::*;

	logic  port_wr;
	logic  port_rd;
	logic  shadow;
	logic  fe_wr;
	logic  p7ffd_wr;
	logic  eff7_wr;
	logic  bf_wr;
	logic  brk_wr;
	logic  up_wr;
	data_t p7ffd_raw; // for BE readback
	data_t peff7_raw;
	data_t up_last;

	bus_strobe u_strobe (
		.fclk, .rst_n, .zpos, .iorq_n, .rd_n, .wr_n,
		.port_wr, .port_rd
	);

	port_decode u_decode (
		.a, .shadow, .port_wr, .porthit, .fe_wr, .beeper_wr, .p7ffd_wr,
		.eff7_wr, .bf_wr, .be_wr(clr_nmi), .brk_wr, .up_wr
	);

	config_regs u_regs (
		.fclk, .rst_n, .dos, .a, .din, .fe_wr, .p7ffd_wr, .eff7_wr, .bf_wr,
		.brk_wr, .shadow, .romrw_en, .font_wr_en, .set_nmi, .brk_ena, .border,
		.p7ffd_raw, .peff7_raw, .p7ffd, .peff7, .brk_addr, .pent1m_page,
		.pent1m_rom, .pent1m_1m_on, .pent1m_ram0_0
	);

	ulaplus_ctrl u_ulaplus (
		.fclk, .rst_n, .a, .din, .up_wr, .up_ena, .up_paladdr, .up_paldata,
		.up_last, .up_palwr
	);

	read_mux u_rdmux (
		.a, .shadow, .iorq_n, .rd_n, .porthit, .tape_read, .keys_in, .kj_in,
		.mus_in, .romrw_en, .font_wr_en, .set_nmi, .brk_ena, .border,
		.p7ffd_raw, .peff7_raw, .brk_addr, .up_last, .dout, .dataout
	);

	// strobe lands while the z80 still holds the read cycle
	a_rd_in_cycle: assert property (@(posedge fclk) disable iff (!rst_n)
		port_rd |-> (!iorq_n && !rd_n));

endmodule

`default_nettype wire

/* rtl/read_mux.sv */
/*
 Read data for the z80: per-port byte select and BE readback.
 Purely combinational, dataout enables the bus driver.
*/
`timescale 1ns/1ps
`default_nettype none

module read_mux (
	input  wire zport_pkg::addr_t  a,
	input  wire logic              shadow,
	input  wire logic              iorq_n,
	input  wire logic              rd_n,
	input  wire logic              porthit,
	input  wire logic              tape_read,
	input  wire logic [4:0]        keys_in,
	input  wire logic [4:0]        kj_in,
	input  wire zport_pkg::data_t  mus_in,
	input  wire logic              romrw_en,
	input  wire logic              font_wr_en,
	input  wire logic              set_nmi,
	input  wire logic              brk_ena,
	input  wire zcfg_pkg::border_t border,
	input  wire zport_pkg::data_t  p7ffd_raw,
	input  wire zport_pkg::data_t  peff7_raw,
	input  wire zport_pkg::addr_t  brk_addr,
	input  wire zport_pkg::data_t  up_last,
	output zport_pkg::data_t       dout,
	output logic                   dataout
);
	import zport_pkg::*;
	import zcfg_pkg::*;

	loa_t      loa;
	be_index_t be_idx;
	data_t     be_data;

	assign loa    = a[7:0];
	assign be_idx = a[12:8];

	// BE readback
	always_comb
	begin
		case (be_idx)
			be_p7ffd:  be_data = p7ffd_raw; // unmasked
			be_peff7:  be_data = peff7_raw;
			be_border: be_data = {4'hF, border};
			be_brk_lo: be_data = brk_addr[7:0];
			be_brk_hi: be_data = brk_addr[15:8];
			default:   be_data = 8'hFF;
		endcase
	end

	always_comb
	begin
		case (loa)
			port_fe, port_f6: dout = {1'b1, tape_read, 1'b0, keys_in};
			port_kjoy:        dout = shadow ? 8'hFF : {3'b000, kj_in}; // disk port in shadow
			port_kmouse:      dout = mus_in;
			port_zxevbf:      dout = {3'b000, brk_ena, set_nmi, font_wr_en, romrw_en, shadow};
			port_zxevbe:      dout = be_data;
			port_ulaplus:     dout = up_last;
			default:          dout = 8'hFF; // open bus
		endcase
	end

	assign dataout = porthit & ~iorq_n & ~rd_n;

endmodule

`default_nettype wire

/* rtl/ulaplus_ctrl.sv */
/*
 ULAplus port 3B: register select in a14 low, data in a14 high.
 Produces the palette write strobe and the enable flag.
*/
`timescale 1ns/1ps
`default_nettype none

module ulaplus_ctrl (
	input  wire logic             fclk,
	input  wire logic             rst_n,
	input  wire zport_pkg::addr_t a,
	input  wire zport_pkg::data_t din,
	input  wire logic             up_wr,
	output logic                  up_ena,
	output zcfg_pkg::page_t       up_paladdr,
	output zport_pkg::data_t      up_paldata,
	output zport_pkg::data_t      up_last,
	output logic                  up_palwr
);
	import zcfg_pkg::*;

	up_mode_t up_mode;
	logic     sel_wr; // register select
	logic     dat_wr; // data

	assign sel_wr = up_wr && !a[14];
	assign dat_wr = up_wr && a[14];

	// mode group in din[7:6], 1x reserved
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			up_mode <= up_mode_ctrl;
		else if (sel_wr && (din[7:6] == 2'b01))
			up_mode <= up_mode_pal;
		else if (sel_wr && (din[7:6] == 2'b00))
			up_mode <= up_mode_ctrl;
	end

	always_ff @(posedge fclk)
	begin
		if (sel_wr && (din[7:6] == 2'b00))
			up_paladdr <= din[5:0];
		if (dat_wr)
			up_last <= din; // read back on 3B
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			up_ena <= 1'b0;
		else if (dat_wr && (up_mode == up_mode_ctrl))
			up_ena <= din[0];
	end

	assign up_palwr   = dat_wr && (up_mode == up_mode_pal);
	assign up_paldata = {din[4:2], din[7:5], din[1:0]}; // G3R3B2 to R3G3B2

endmodule

`default_nettype wire

/* rtl/config_regs.sv */
/*
 Paging, extended config, BF config, border and breakpoint registers.
 Written on the decode strobes. Also derives the pent1m paging outputs.
*/
`timescale 1ns/1ps
`default_nettype none

module config_regs (
	input  wire logic             fclk,
	input  wire logic             rst_n,
	input  wire logic             dos,
	input  wire zport_pkg::addr_t a,
	input  wire zport_pkg::data_t din,
	input  wire logic             fe_wr,
	input  wire logic             p7ffd_wr,
	input  wire logic             eff7_wr,
	input  wire logic             bf_wr,
	input  wire logic             brk_wr,
	output logic                  shadow,
	output logic                  romrw_en,
	output logic                  font_wr_en,
	output logic                  set_nmi,
	output logic                  brk_ena,
	output zcfg_pkg::border_t     border,
	output zport_pkg::data_t      p7ffd_raw,
	output zport_pkg::data_t      peff7_raw,
	output zport_pkg::data_t      p7ffd,
	output zport_pkg::data_t      peff7,
	output zport_pkg::addr_t      brk_addr,
	output zcfg_pkg::page_t       pent1m_page,
	output logic                  pent1m_rom,
	output logic                  pent1m_1m_on,
	output logic                  pent1m_ram0_0
);
	import zport_pkg::*;
	import zcfg_pkg::*;

	logic shadow_en; // BF bit 0
	logic block1m;
	logic block7ffd;

	assign block1m   = peff7_raw[eff7_block1m];
	assign block7ffd = p7ffd_raw[p7ffd_lock] & block1m; // 48k lock

	////////////////////
	// paging ports
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_raw <= '0;
			peff7_raw <= '0;
		end
		else
		begin
			if (p7ffd_wr && !block7ffd)
				p7ffd_raw <= din; // 2..0 page, 3 screen, 4 rom, 7..5 hi page
			if (eff7_wr)
				peff7_raw <= din;
		end
	end

	// BF config
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			shadow_en  <= 1'b0;
			romrw_en   <= 1'b0;
			font_wr_en <= 1'b0;
			set_nmi    <= 1'b0;
			brk_ena    <= 1'b0;
		end
		else if (bf_wr)
		begin
			shadow_en  <= din[bf_shadow];
			romrw_en   <= din[bf_romrw];
			font_wr_en <= din[bf_fntw];
			set_nmi    <= din[bf_nmi];
			brk_ena    <= din[bf_brk];
		end
	end

	// border and breakpoint
	always_ff @(posedge fclk)
	begin
		if (fe_wr)
			border <= {~a[3], din[2:0]}; // bright from ~a3
		if (brk_wr)
		begin
			if (a[8])
				brk_addr[15:8] <= din;
			else
				brk_addr[7:0] <= din;
		end
	end

	assign shadow = dos | shadow_en;

	////////////////////
	// 128k view of the paging outputs while block1m
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_raw[7:5]), p7ffd_raw[4:0]};
	assign peff7 = block1m ? (peff7_raw & 8'b1011_0001) : peff7_raw; // drop 6,3,2,1

	assign pent1m_page   = {p7ffd_raw[7:5], p7ffd_raw[2:0]};
	assign pent1m_rom    = p7ffd_raw[4];
	assign pent1m_1m_on  = ~peff7_raw[eff7_block1m];
	assign pent1m_ram0_0 = peff7_raw[eff7_ram0];

endmodule

`default_nettype wire

/* rtl/port_decode.sv */
/*
 Port map decode that makes the bus hit flag and the per-port
 write strobes from the fclk write pulse.
*/
`timescale 1ns/1ps
`default_nettype none

module port_decode (
	input  wire zport_pkg::addr_t a,
	input  wire logic             shadow,
	input  wire logic             port_wr,
	output logic                  porthit,
	output logic                  fe_wr,
	output logic                  beeper_wr,
	output logic                  p7ffd_wr,
	output logic                  eff7_wr,
	output logic                  bf_wr,
	output logic                  be_wr,
	output logic                  brk_wr,
	output logic                  up_wr
);
	import zport_pkg::*;

	loa_t loa;

	assign loa = a[7:0];

	// ports answered by this block
	always_comb
	begin
		porthit = (loa == port_fe) || (loa == port_f6) || (loa == port_fd) ||
		          (loa == port_kmouse) ||
		          ((loa == port_kjoy) && !shadow) || // 1F is the disk port in shadow
		          ((loa == port_f7) && !shadow) ||
		          (loa == port_zxevbf) || (loa == port_zxevbe) ||
		          (loa == port_zxevbrk) || (loa == port_ulaplus);
	end

	////////////////////
	// write strobes

	assign fe_wr     = port_wr && ((loa == port_fe) || (loa == port_f6));
	assign beeper_wr = port_wr && (loa == port_fe); // F6 is silent
	assign p7ffd_wr  = port_wr && (loa == port_fd) && !a[15]; // a15 high is AY
	// xEF7 only as a12 high is the gluclock space
	assign eff7_wr   = port_wr && (loa == port_f7) && a[8] && !a[12] && !shadow;
	assign bf_wr     = port_wr && (loa == port_zxevbf);
	assign be_wr     = port_wr && (loa == port_zxevbe);
	assign brk_wr    = port_wr && (loa == port_zxevbrk);
	assign up_wr     = port_wr && (loa == port_ulaplus);

endmodule

`default_nettype wire

/* rtl/bus_strobe.sv */
/*
 Turns z80 i/o read and write cycles into single fclk pulses.
 Control lines are sampled only on zpos.
*/
`timescale 1ns/1ps
`default_nettype none

module bus_strobe (
	input  wire logic fclk,
	input  wire logic rst_n,
	input  wire logic zpos,
	input  wire logic iorq_n,
	input  wire logic rd_n,
	input  wire logic wr_n,
	output logic      port_wr,
	output logic      port_rd
);

	logic       wr_smp; // io write seen on last zpos
	logic       rd_smp;
	logic [1:0] wr_dly; // fclk-delayed copies
	logic [1:0] rd_dly;

	// sample at z80 clock rate
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_smp <= 1'b0;
			rd_smp <= 1'b0;
		end
		else if (zpos)
		begin
			wr_smp <= ~(iorq_n | wr_n);
			rd_smp <= ~(iorq_n | rd_n);
		end
	end

	// rising edge of the sample, two edges late
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_dly  <= 2'b00;
			rd_dly  <= 2'b00;
			port_wr <= 1'b0;
			port_rd <= 1'b0;
		end
		else
		begin
			wr_dly  <= {wr_dly[0], wr_smp};
			rd_dly  <= {rd_dly[0], rd_smp};
			port_wr <= wr_dly[0] & ~wr_dly[1]; // one cycle only
			port_rd <= rd_dly[0] & ~rd_dly[1];
		end
	end

	// z80 never reads and writes in one io cycle
	a_no_rd_wr: assert property (@(posedge fclk) disable iff (!rst_n)
		!(port_wr && port_rd));

endmodule

`default_nettype wire

/* rtl/zcfg_pkg.sv */
/*
 Layout of the config registers: field positions, readback indices
 of port BE and the ULAplus mode encoding.
*/
`default_nettype none

package zcfg_pkg;

	typedef logic [3:0] border_t;   // border colour, top bit from ~a3
	typedef logic [5:0] page_t;     // 1M page number
	typedef logic [4:0] be_index_t; // a[12:8] on BE reads

	////////////////////
	// BF bits
	localparam int bf_shadow = 0;
	localparam int bf_romrw  = 1;
	localparam int bf_fntw   = 2;
	localparam int bf_nmi    = 3;
	localparam int bf_brk    = 4;

	// EFF7 and 7FFD bits
	localparam int eff7_block1m = 2; // also blocks 7FFD[7:5]
	localparam int eff7_ram0    = 3;
	localparam int eff7_glu     = 7; // gluclock enable, stored only
	localparam int p7ffd_lock   = 5; // 48k lock, only with block1m

	////////////////////
	// BE readback
	localparam be_index_t be_p7ffd   = 5'h0A;
	localparam be_index_t be_peff7   = 5'h0B;
	localparam be_index_t be_border  = 5'h0F;
	localparam be_index_t be_brk_lo  = 5'h10;
	localparam be_index_t be_brk_hi  = 5'h11;

	typedef enum logic {up_mode_ctrl, up_mode_pal} up_mode_t;

endpackage

`default_nettype wire

/* rtl/zport_pkg.sv */
/*
 Z80 bus widths and the I/O port map of the port block.
 Shared by the decode, the read path and the testbench.
*/
`default_nettype none

package zport_pkg;

	typedef logic [15:0] addr_t; // full z80 address
	typedef logic [7:0]  data_t; // one data byte
	typedef logic [7:0]  loa_t;  // low address byte, the port number

	////////////////////
	// port numbers

	localparam loa_t port_fe      = 8'hFE; // keyboard, tape, border, beeper
	localparam loa_t port_f6      = 8'hF6; // alias of FE without beeper
	localparam loa_t port_fd      = 8'hFD; // 7FFD paging when a15 low
	localparam loa_t port_f7      = 8'hF7; // EFF7 extended config
	localparam loa_t port_kjoy    = 8'h1F; // kempston joystick
	localparam loa_t port_kmouse  = 8'hDF; // kempston mouse

	localparam loa_t port_zxevbf  = 8'hBF; // config write/read
	localparam loa_t port_zxevbe  = 8'hBE; // readback, nmi end
	localparam loa_t port_zxevbrk = 8'hBD; // breakpoint address
	localparam loa_t port_ulaplus = 8'h3B; // ulaplus control/data

endpackage

`default_nettype wire
